// ==== common/icache_pkg.sv ====
package icache_pkg;

    // ============================================================
    // cache geometry
    // ============================================================

    localparam int icache_line_count = 16;  // one 32-bit word per line.
    localparam int icache_index_bits = 4;   // address bits 5..2.
    localparam int icache_tag_bits   = 26;  // address bits 31..6.

    // ============================================================
    // address views
    // ============================================================

    typedef struct packed {
        logic [icache_tag_bits-1:0]   tag;
        logic [icache_index_bits-1:0] index;
        logic [1:0]                   offset;  // byte within the word.
    } icache_addr_fields_t;

    // raw goes to memory, fields feed the stores.
    typedef union packed {
        logic [31:0]         raw;
        icache_addr_fields_t fields;
    } icache_addr_u;

    // ============================================================
    // controller state and refill bundle
    // ============================================================

    typedef enum logic [1:0] {
        icache_idle     = 2'd0,
        icache_compare  = 2'd1,
        icache_allocate = 2'd2
    } icache_state_e;

    typedef struct packed {
        logic                         en;
        logic [icache_index_bits-1:0] index;
        logic [icache_tag_bits-1:0]   tag;
        logic [31:0]                  word;
    } icache_fill_t;

endpackage

// ==== design/icache_top.sv ====
`timescale 1ns/1ps

// the controller steps through icache_state_e (idle, compare, allocate).
// hits answer one cycle after the request is sampled. misses wait on memory.
module icache_top (
    input  logic        clk,
    input  logic        rst,
    // cpu side
    input  logic [31:0] cpu_req_addr,
    input  logic        cpu_req_valid,
    output logic        cpu_req_ready,
    output logic [31:0] cpu_req_data,
    input  logic        flush,
    // memory side
    output logic [31:0] mem_req_addr,
    output logic        mem_req_valid,
    input  logic [31:0] mem_req_data,
    input  logic        mem_req_ready
);
    import icache_pkg::*;

    logic                         flush_lines;
    logic [icache_index_bits-1:0] lookup_index;
    icache_fill_t                 fill;
    logic                         line_valid;
    logic [icache_tag_bits-1:0]   line_tag;
    logic [31:0]                  line_word;

    icache_ctrl ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .flush         (flush),
        .flush_lines   (flush_lines),
        .lookup_index  (lookup_index),
        .line_valid    (line_valid),
        .line_tag      (line_tag),
        .line_word     (line_word),
        .fill          (fill),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    // both stores see the same index and fill.
    icache_tag_store tag_store_inst (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush_lines),
        .lookup_index (lookup_index),
        .fill         (fill),
        .line_valid   (line_valid),
        .line_tag     (line_tag)
    );

    icache_data_store data_store_inst (
        .clk          (clk),
        .lookup_index (lookup_index),
        .fill         (fill),
        .line_word    (line_word)
    );

endmodule

// ==== filelist.f ====
common/icache_pkg.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
icache/icache_ctrl.sv
design/icache_top.sv
tb/icache_mem_model.sv
tb/icache_tb.sv

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                                     clk,
    input  logic                                     rst,
    // cpu side
    input  icache_pkg::icache_addr_u                 cpu_req_addr,
    input  logic                                     cpu_req_valid,
    output logic                                     cpu_req_ready,
    output logic [31:0]                              cpu_req_data,
    input  logic                                     flush,
    // store side
    output logic                                     flush_lines,
    output logic [icache_pkg::icache_index_bits-1:0] lookup_index,
    input  logic                                     line_valid,
    input  logic [icache_pkg::icache_tag_bits-1:0]   line_tag,
    input  logic [31:0]                              line_word,
    output icache_pkg::icache_fill_t                 fill,
    // memory side
    output logic [31:0]                              mem_req_addr,
    output logic                                     mem_req_valid,
    input  logic [31:0]                              mem_req_data,
    input  logic                                     mem_req_ready
);
    import icache_pkg::*;

    icache_state_e state;
    icache_state_e state_next;

    icache_addr_u aligned_addr;
    logic         hit;

    // ============================================================
    // lookup and hit
    // ============================================================

    assign lookup_index = cpu_req_addr.fields.index;
    assign flush_lines  = flush && (state == icache_idle);

    assign hit = line_valid && (line_tag == cpu_req_addr.fields.tag);

    assign cpu_req_ready = (state == icache_compare) && hit;
    assign cpu_req_data  = line_word;

    always_comb
    begin
        aligned_addr               = cpu_req_addr;
        aligned_addr.fields.offset = 2'b00;  // word-aligned refill.
    end

    // ============================================================
    // state machine
    // ============================================================

    always_comb
    begin
        state_next = state;
        case (state)
            icache_idle:
            begin
                if (!flush && cpu_req_valid)
                begin
                    state_next = icache_compare;  // flush wins, request waits.
                end
            end
            icache_compare:
            begin
                state_next = hit ? icache_idle : icache_allocate;
            end
            icache_allocate:
            begin
                if (mem_req_ready)
                begin
                    state_next = icache_compare;  // re-read stores, then hit.
                end
            end
            default:
            begin
                state_next = icache_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= icache_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // ============================================================
    // refill request
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (state == icache_compare && !hit)
        begin
            mem_req_valid <= 1'b1;
        end
        else if (mem_req_ready)
        begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == icache_compare && !hit)
        begin
            mem_req_addr <= aligned_addr.raw;
        end
    end

    always_comb
    begin
        fill.en    = (state == icache_allocate) && mem_req_ready;
        fill.index = cpu_req_addr.fields.index;
        fill.tag   = cpu_req_addr.fields.tag;
        fill.word  = mem_req_data;
    end

    // ============================================================
    // protocol checks
    // ============================================================

    // allocate is left only on mem_req_ready.
    a_mem_valid_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid == (state == icache_allocate)
    );

    a_no_ready_during_refill: assert property (
        @(posedge clk) disable iff (rst) mem_req_valid |-> !cpu_req_ready
    );

    a_flush_only_idle: assert property (
        @(posedge clk) disable iff (rst) flush |-> state == icache_idle
    );

endmodule

// ==== icache/icache_data_store.sv ====
`timescale 1ns/1ps

module icache_data_store (
    input  logic                                     clk,
    input  logic [icache_pkg::icache_index_bits-1:0] lookup_index,
    input  icache_pkg::icache_fill_t                 fill,
    output logic [31:0]                              line_word
);
    import icache_pkg::*;

    // ============================================================
    // instruction word array
    // ============================================================

    logic [31:0] word_mem [icache_line_count];

    always_ff @(posedge clk)
    begin
        if (fill.en)
        begin
            word_mem[fill.index] <= fill.word;
        end
    end

    // registered read, new word forwarded when the refill hits this line.
    always_ff @(posedge clk)
    begin
        if (fill.en && (fill.index == lookup_index))
        begin
            line_word <= fill.word;
        end
        else
        begin
            line_word <= word_mem[lookup_index];
        end
    end

endmodule

// ==== icache/icache_tag_store.sv ====
`timescale 1ns/1ps

module icache_tag_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic [icache_pkg::icache_index_bits-1:0] lookup_index,
    input  icache_pkg::icache_fill_t               fill,
    output logic                                   line_valid,
    output logic [icache_pkg::icache_tag_bits-1:0] line_tag
);
    import icache_pkg::*;

    logic [icache_line_count-1:0] valid_bits;
    logic [icache_tag_bits-1:0]   tag_mem [icache_line_count];

    logic fill_hits_lookup;

    assign fill_hits_lookup = fill.en && (fill.index == lookup_index);

    // valid bits are control state and follow reset and flush.
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid_bits <= '0;
        end
        else if (fill.en)
        begin
            valid_bits[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill.en)
        begin
            tag_mem[fill.index] <= fill.tag;
        end
    end

    // synchronous read, write-first so the compare after a refill hits.
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            line_valid <= 1'b0;
        end
        else if (fill_hits_lookup)
        begin
            line_valid <= 1'b1;
        end
        else
        begin
            line_valid <= valid_bits[lookup_index];
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_hits_lookup)
        begin
            line_tag <= fill.tag;
        end
        else
        begin
            line_tag <= tag_mem[lookup_index];
        end
    end

    // flush is only taken in idle, refills only in allocate.
    a_no_flush_during_fill: assert property (
        @(posedge clk) disable iff (rst) !(flush && fill.en)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -f filelist.f -o icache_sim \
    && ./obj_dir/icache_sim | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

// ==== tb/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_req_addr,
    input  logic        mem_req_valid,
    output logic [31:0] mem_req_data,
    output logic        mem_req_ready,
    input  logic [2:0]  delay,
    output logic [31:0] request_count,
    output logic [31:0] last_addr
);

    logic       busy;
    logic [2:0] wait_left;

    // word at address A is A xor a fixed pattern.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy          <= 1'b0;
            wait_left     <= 3'd0;
            mem_req_ready <= 1'b0;
            mem_req_data  <= 32'd0;
            request_count <= 32'd0;
            last_addr     <= 32'd0;
        end
        else
        begin
            mem_req_ready <= 1'b0;  // one-cycle pulse.
            if (!busy && mem_req_valid && !mem_req_ready)
            begin
                busy          <= 1'b1;
                wait_left     <= delay;  // delay latched per request.
                request_count <= request_count + 32'd1;
                last_addr     <= mem_req_addr;
            end
            else if (busy)
            begin
                if (wait_left == 3'd0)
                begin
                    mem_req_ready <= 1'b1;
                    mem_req_data  <= last_addr ^ 32'h5a5a_0f0f;
                    busy          <= 1'b0;
                end
                else
                begin
                    wait_left <= wait_left - 3'd1;
                end
            end
        end
    end

endmodule

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    typedef struct packed {
        logic        is_flush;
        logic        miss;
        logic [31:0] addr;
    } row_t;

    localparam int ready_timeout = 200;

    logic        clk;
    logic        rst;
    logic [31:0] cpu_req_addr;
    logic        cpu_req_valid;
    logic        cpu_req_ready;
    logic [31:0] cpu_req_data;
    logic        flush;
    logic [31:0] mem_req_addr;
    logic        mem_req_valid;
    logic [31:0] mem_req_data;
    logic        mem_req_ready;
    logic [2:0]  mem_delay;
    logic [31:0] mem_req_count;
    logic [31:0] mem_last_addr;

    logic [31:0] lfsr_state;
    int          error_count;
    int          timeout_count;
    row_t        rows[$];
    logic        shadow_valid [16];
    logic [25:0] shadow_tag [16];

    icache_top icache_top_inst (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_addr  (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_req_data  (cpu_req_data),
        .flush         (flush),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    icache_mem_model mem_inst (
        .clk           (clk),
        .rst           (rst),
        .mem_req_addr  (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data  (mem_req_data),
        .mem_req_ready (mem_req_ready),
        .delay         (mem_delay),
        .request_count (mem_req_count),
        .last_addr     (mem_last_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // table rows keep the shadow of a direct-mapped cache up to date.
    task automatic add_req(input logic [31:0] addr, input logic miss);
        rows.push_back('{is_flush: 1'b0, miss: miss, addr: addr});
        shadow_valid[addr[5:2]] = 1'b1;
        shadow_tag[addr[5:2]]   = addr[31:6];
    endtask

    task automatic add_random_req(input logic [31:0] addr);
        add_req(addr, !(shadow_valid[addr[5:2]] && shadow_tag[addr[5:2]] == addr[31:6]));
    endtask

    task automatic add_flush();
        rows.push_back('{is_flush: 1'b1, miss: 1'b0, addr: 32'd0});
        for (int i = 0; i < 16; i++)
        begin
            shadow_valid[i] = 1'b0;
        end
    endtask

    task automatic run_request(input row_t row);
        logic [31:0] delay_bits;
        logic [31:0] count_before;
        logic        got_ready;
        int          waited;
        take_bits(3, delay_bits);
        mem_delay     = delay_bits[2:0];
        count_before  = mem_req_count;
        cpu_req_addr  = row.addr;
        cpu_req_valid = 1'b1;
        got_ready     = 1'b0;
        waited        = 0;
        while (!got_ready && waited < ready_timeout)
        begin
            @(negedge clk);
            waited    = waited + 1;
            got_ready = cpu_req_ready;
        end
        cpu_req_valid = 1'b0;
        if (!got_ready)
        begin
            $display("timeout: no cpu_req_ready for address %h after %0d cycles",
                     row.addr, ready_timeout);
            timeout_count++;
        end
        else
        begin
            check_value("cpu_req_data", cpu_req_data, expected_word(row.addr));
            check_value("memory request count", mem_req_count - count_before, 32'(row.miss));
            if (row.miss)
            begin
                check_value("mem_req_addr", mem_last_addr, {row.addr[31:2], 2'b00});
            end
            else
            begin
                check_value("hit latency", waited, 32'd1);  // ready right after the sample.
            end
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================

    initial
    begin
        logic [31:0] bits;
        rst           = 1'b1;
        cpu_req_addr  = 32'd0;
        cpu_req_valid = 1'b0;
        flush         = 1'b0;
        mem_delay     = 3'd0;
        lfsr_state    = 32'h2f11;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < 16; i++)
        begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end

        add_req(32'h0000_0104, 1'b1);  // index 1, tag 4.
        add_req(32'h0000_0104, 1'b0);
        add_req(32'h0000_0107, 1'b0);  // other byte, same word.
        add_req(32'h0000_0118, 1'b1);  // index 6.
        add_req(32'h0000_0204, 1'b1);  // index 1, tag 8.
        add_req(32'h0000_0104, 1'b1);
        add_req(32'h0000_0204, 1'b1);
        add_req(32'h0000_0118, 1'b0);
        add_req(32'h0000_0104, 1'b1);
        add_flush();
        add_req(32'h0000_0104, 1'b1);
        add_req(32'h0000_0118, 1'b1);
        add_req(32'h0000_0105, 1'b0);
        add_req(32'h0000_011a, 1'b0);
        for (int i = 0; i < 40; i++)
        begin
            take_bits(8, bits);
            add_random_req(32'h0000_8000 | {24'd0, bits[7:0]});  // four tags share 16 lines.
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("cpu_req_ready", 32'(cpu_req_ready), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);

        foreach (rows[i])
        begin
            @(negedge clk);
            if (rows[i].is_flush)
            begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            else
            begin
                run_request(rows[i]);
            end
            if (timeout_count != 0)
            begin
                break;
            end
        end

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
